//--- include/gpu_defines.svh
/*
 * Width helpers shared by the execution cluster RTL.
 * Include after the timescale line in any module that sizes an index field.
 */
`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

// Ceiling log2, never less than one bit so a one-entry index still has a wire
`define CLOG2_UP(x) (((x) > 1) ? $clog2(x) : 1)

// Number of lane packets that cover a warp of the given thread count
`define PKT_COUNT(threads, lanes) ((threads) / (lanes))

`endif

//--- source/gpu_pkg.sv
/*
 * Core-wide constants, the ALU opcode encoding and the stream payloads.
 * Every module of the execution cluster imports this package by wildcard.
 */
package gpu_pkg;

    localparam int NUM_THREADS = 8;
    localparam int XLEN        = 32;
    localparam int NUM_WARPS   = 8;
    localparam int NW_BITS     = 3;
    localparam int UUID_BITS   = 8;
    localparam int NR_BITS     = 5;

    // Lane packets are sized for the widest block, narrower blocks use the low lanes
    localparam int MAX_LANES = NUM_THREADS;
    localparam int PID_BITS  = 3;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5
    } alu_op_e;

    // Whole-warp instruction as handed over by the issue stage
    typedef struct packed {
        logic [UUID_BITS-1:0]                  uuid;
        logic [NW_BITS-1:0]                    wid;
        logic [NUM_THREADS-1:0]                tmask;
        logic [XLEN-1:0]                       pc;
        alu_op_e                               op;
        logic [NR_BITS-1:0]                    rd;
        logic                                  wb;
        logic [NUM_THREADS-1:0][XLEN-1:0]      rs1;
        logic [NUM_THREADS-1:0][XLEN-1:0]      rs2;
    } issue_req_t;

    // Full-width result presented on a commit port
    typedef struct packed {
        logic [UUID_BITS-1:0]                  uuid;
        logic [NW_BITS-1:0]                    wid;
        logic [NUM_THREADS-1:0]                tmask;
        logic [XLEN-1:0]                       pc;
        logic                                  wb;
        logic [NR_BITS-1:0]                    rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]      data;
        logic                                  sop;
        logic                                  eop;
    } commit_t;

    typedef struct packed {
        logic [UUID_BITS-1:0]                  uuid;
        logic [NW_BITS-1:0]                    wid;
        logic [MAX_LANES-1:0]                  tmask;
        logic [XLEN-1:0]                       pc;
        alu_op_e                               op;
        logic [NR_BITS-1:0]                    rd;
        logic                                  wb;
        logic [MAX_LANES-1:0][XLEN-1:0]        rs1;
        logic [MAX_LANES-1:0][XLEN-1:0]        rs2;
        logic [PID_BITS-1:0]                   pid;
        logic                                  sop;
        logic                                  eop;
    } lane_pkt_t;

    typedef struct packed {
        logic [UUID_BITS-1:0]                  uuid;
        logic [NW_BITS-1:0]                    wid;
        logic [MAX_LANES-1:0]                  tmask;
        logic [XLEN-1:0]                       pc;
        logic [NR_BITS-1:0]                    rd;
        logic                                  wb;
        logic [MAX_LANES-1:0][XLEN-1:0]        data;
        logic [PID_BITS-1:0]                   pid;
        logic                                  sop;
        logic                                  eop;
    } lane_res_t;

endpackage

//--- source/lane_dispatch.sv
/*
 * Splits one warp instruction into lane packets and sends them to the ALU
 * block of the instruction's issue slot. Serves one instruction at a time.
 */
`timescale 1ns/1ps
`include "gpu_defines.svh"

module lane_dispatch import gpu_pkg::*; #(
    parameter int NUM_LANES  = 2,
    parameter int ISSUE_CNT  = 4,
    parameter int BLOCK_SIZE = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  issue_valid,
    input  issue_req_t            issue_data,
    output logic                  issue_ready,

    output logic [BLOCK_SIZE-1:0] pkt_valid,
    output lane_pkt_t             pkt_data,
    input  logic [BLOCK_SIZE-1:0] pkt_ready
);
    localparam int NUM_PKTS  = `PKT_COUNT(NUM_THREADS, NUM_LANES);
    localparam int PKT_IDX_W = `CLOG2_UP(NUM_PKTS);
    localparam int SLOT_W    = `CLOG2_UP(ISSUE_CNT);
    localparam int BLK_W     = `CLOG2_UP(BLOCK_SIZE);

    logic                 busy_r;
    logic                 sop_r;
    logic [PKT_IDX_W-1:0] pid_r;
    issue_req_t           req_r;

    logic [PKT_IDX_W:0]   first_sel;
    logic [PKT_IDX_W:0]   next_sel;
    logic                 next_hit;
    logic [SLOT_W-1:0]    slot;
    logic [BLK_W-1:0]     blk;
    logic                 issue_fire;
    logic                 pkt_fire;

    // Lowest packet index at or above 'from' whose mask slice has a live thread,
    // with the found flag in the top bit
    function automatic logic [PKT_IDX_W:0] find_slice(input logic [NUM_THREADS-1:0] mask,
                                                      input int from);
        logic [PKT_IDX_W:0] res;
        res = '0;
        for (int p = NUM_PKTS - 1; p >= 0; p--) begin
            if (p >= from && |mask[p*NUM_LANES +: NUM_LANES]) begin
                res = {1'b1, PKT_IDX_W'(p)};
            end
        end
        return res;
    endfunction

    assign first_sel = find_slice(issue_data.tmask, 0);
    assign next_sel  = find_slice(req_r.tmask, int'(pid_r) + 1);
    assign next_hit  = next_sel[PKT_IDX_W];

    assign slot = SLOT_W'(int'(req_r.wid) % ISSUE_CNT);
    assign blk  = BLK_W'(int'(slot) % BLOCK_SIZE);

    assign issue_ready = !busy_r;
    assign issue_fire  = issue_valid && issue_ready;
    assign pkt_fire    = busy_r && pkt_ready[blk];

    always_comb begin
        pkt_valid      = '0;
        pkt_valid[blk] = busy_r;
    end

    always_comb begin
        pkt_data      = '0;
        pkt_data.uuid = req_r.uuid;
        pkt_data.wid  = req_r.wid;
        pkt_data.pc   = req_r.pc;
        pkt_data.op   = req_r.op;
        pkt_data.rd   = req_r.rd;
        pkt_data.wb   = req_r.wb;
        pkt_data.pid  = PID_BITS'(pid_r);
        pkt_data.sop  = sop_r;
        pkt_data.eop  = !next_hit;
        for (int l = 0; l < NUM_LANES; l++) begin
            pkt_data.tmask[l] = req_r.tmask[pid_r*NUM_LANES + l];
            pkt_data.rs1[l]   = req_r.rs1[pid_r*NUM_LANES + l];
            pkt_data.rs2[l]   = req_r.rs2[pid_r*NUM_LANES + l];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_r <= 1'b0;
            sop_r  <= 1'b0;
            pid_r  <= '0;
        end else if (issue_fire) begin
            // An all-zero mask has nothing to send and is dropped here
            busy_r <= first_sel[PKT_IDX_W];
            sop_r  <= 1'b1;
            pid_r  <= first_sel[PKT_IDX_W-1:0];
        end else if (pkt_fire) begin
            if (next_hit) begin
                pid_r <= next_sel[PKT_IDX_W-1:0];
                sop_r <= 1'b0;
            end else begin
                busy_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            req_r <= issue_data;
        end
    end

    // The issue stage never hands over a warp with no active thread
    a_issue_mask: assert property (@(posedge clk) disable iff (!rst_n)
        issue_fire |-> (issue_data.tmask != '0));

endmodule

//--- source/alu_lanes.sv
/*
 * One ALU block. Computes the opcode for each active lane of a packet and
 * holds the result with its tags in a single valid/ready pipeline register.
 */
`timescale 1ns/1ps

module alu_lanes import gpu_pkg::*; #(
    parameter int NUM_LANES = 2
) (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      pkt_valid,
    input  lane_pkt_t pkt_data,
    output logic      pkt_ready,

    output logic      res_valid,
    output lane_res_t res_data,
    input  logic      res_ready
);
    logic      valid_r;
    lane_res_t res_r;
    lane_res_t res_next;

    function automatic logic [XLEN-1:0] alu_calc(input alu_op_e op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        logic [XLEN-1:0] r;
        case (op)
            ADD:     r = a + b;
            SUB:     r = a - b;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            SLT:     r = XLEN'($signed(a) < $signed(b));
            default: r = '0;
        endcase
        return r;
    endfunction

    always_comb begin
        res_next       = '0;
        res_next.uuid  = pkt_data.uuid;
        res_next.wid   = pkt_data.wid;
        res_next.tmask = pkt_data.tmask;
        res_next.pc    = pkt_data.pc;
        res_next.rd    = pkt_data.rd;
        res_next.wb    = pkt_data.wb;
        res_next.pid   = pkt_data.pid;
        res_next.sop   = pkt_data.sop;
        res_next.eop   = pkt_data.eop;
        // Lanes above NUM_LANES and inactive lanes stay zero
        for (int l = 0; l < NUM_LANES; l++) begin
            if (pkt_data.tmask[l]) begin
                res_next.data[l] = alu_calc(pkt_data.op, pkt_data.rs1[l], pkt_data.rs2[l]);
            end
        end
    end

    // The register accepts whenever it is empty or being drained this cycle
    assign pkt_ready = res_ready || !valid_r;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else if (pkt_ready) begin
            valid_r <= pkt_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_ready && pkt_valid) begin
            res_r <= res_next;
        end
    end

    assign res_valid = valid_r;
    assign res_data  = res_r;

    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_data)));

endmodule

//--- source/elastic_buffer.sv
/*
 * Valid/ready stage for lane results. OUT_REG=0 passes the stream straight
 * through, OUT_REG=1 adds a two-entry skid buffer with a registered output.
 */
`timescale 1ns/1ps

module elastic_buffer import gpu_pkg::*; #(
    parameter int OUT_REG = 1
) (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      valid_in,
    output logic      ready_in,
    input  lane_res_t data_in,

    output logic      valid_out,
    input  logic      ready_out,
    output lane_res_t data_out
);
    if (OUT_REG == 0) begin : g_bypass
        assign valid_out = valid_in;
        assign data_out  = data_in;
        assign ready_in  = ready_out;
    end else begin : g_skid
        logic      out_valid_r;
        lane_res_t out_data_r;
        logic      skid_valid_r;
        lane_res_t skid_data_r;
        logic      out_load;

        // Input stalls only once the skid entry behind a full output is taken
        assign ready_in = !skid_valid_r;
        assign out_load = !out_valid_r || ready_out;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                out_valid_r  <= 1'b0;
                skid_valid_r <= 1'b0;
            end else if (out_load) begin
                // The skid entry is older than anything at the input
                out_valid_r  <= skid_valid_r || valid_in;
                skid_valid_r <= 1'b0;
            end else if (valid_in && ready_in) begin
                skid_valid_r <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (out_load) begin
                out_data_r <= skid_valid_r ? skid_data_r : data_in;
            end else if (valid_in && ready_in) begin
                skid_data_r <= data_in;
            end
        end

        assign valid_out = out_valid_r;
        assign data_out  = out_data_r;

        // With both entries held and the output stalled the skid entry is never overwritten
        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
            (out_valid_r && skid_valid_r && !ready_out)
                |=> (skid_valid_r && $stable(skid_data_r)));
    end

endmodule

//--- source/gather_unit.sv
/*
 * Steers ALU block results to the commit port of their issue slot through an
 * elastic buffer per port, then widens each packet to full warp width at its pid.
 */
`timescale 1ns/1ps
`include "gpu_defines.svh"

module gather_unit import gpu_pkg::*; #(
    parameter int NUM_LANES  = 2,
    parameter int ISSUE_CNT  = 4,
    parameter int BLOCK_SIZE = 2,
    parameter int OUT_REG    = 1
) (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic      [BLOCK_SIZE-1:0]       res_valid,
    input  lane_res_t [BLOCK_SIZE-1:0]       res_data,
    output logic      [BLOCK_SIZE-1:0]       res_ready,

    output logic      [ISSUE_CNT-1:0]        commit_valid,
    output commit_t   [ISSUE_CNT-1:0]        commit_data,
    input  logic      [ISSUE_CNT-1:0]        commit_ready
);
    localparam int SLOT_W = `CLOG2_UP(ISSUE_CNT);

    logic      [BLOCK_SIZE-1:0][SLOT_W-1:0] blk_slot;
    logic      [ISSUE_CNT-1:0]              buf_valid;
    lane_res_t [ISSUE_CNT-1:0]              buf_data;
    logic      [ISSUE_CNT-1:0]              buf_ready;

    // Block i owns the slots whose low bits equal i and takes the upper bits from wid
    for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_slot
        assign blk_slot[i] = SLOT_W'(((int'(res_data[i].wid) % ISSUE_CNT) / BLOCK_SIZE)
                                     * BLOCK_SIZE + i);
        assign res_ready[i] = buf_ready[blk_slot[i]];
    end

    always_comb begin
        buf_valid = '0;
        buf_data  = '0;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            buf_valid[blk_slot[i]] = res_valid[i];
            buf_data[blk_slot[i]]  = res_data[i];
        end
    end

    for (genvar p = 0; p < ISSUE_CNT; p++) begin : g_port
        logic      eb_valid;
        lane_res_t eb_data;
        commit_t   wide;

        elastic_buffer #(
            .OUT_REG (OUT_REG)
        ) out_buf (
            .clk       (clk),
            .rst_n     (rst_n),
            .valid_in  (buf_valid[p]),
            .ready_in  (buf_ready[p]),
            .data_in   (buf_data[p]),
            .valid_out (eb_valid),
            .ready_out (commit_ready[p]),
            .data_out  (eb_data)
        );

        // Threads outside this packet's slice come out with mask and data cleared
        always_comb begin
            wide      = '0;
            wide.uuid = eb_data.uuid;
            wide.wid  = eb_data.wid;
            wide.pc   = eb_data.pc;
            wide.wb   = eb_data.wb;
            wide.rd   = eb_data.rd;
            wide.sop  = eb_data.sop;
            wide.eop  = eb_data.eop;
            for (int l = 0; l < NUM_LANES; l++) begin
                wide.tmask[eb_data.pid*NUM_LANES + l] = eb_data.tmask[l];
                wide.data[eb_data.pid*NUM_LANES + l]  = eb_data.data[l];
            end
        end

        assign commit_valid[p] = eb_valid;
        assign commit_data[p]  = wide;
    end

    // Packets held by distinct blocks never belong to the same issue slot
    for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_chk_i
        for (genvar j = i + 1; j < BLOCK_SIZE; j++) begin : g_chk_j
            a_slot_unique: assert property (@(posedge clk) disable iff (!rst_n)
                !(res_valid[i] && res_valid[j]
                  && ((int'(res_data[i].wid) % ISSUE_CNT)
                      == (int'(res_data[j].wid) % ISSUE_CNT))));
        end
    end

endmodule

//--- source/exec_cluster_top.sv
/*
 * Commit path of the SIMT execution unit. Connects the lane dispatcher, the
 * ALU blocks and the gather unit and sets their parameters.
 */
`timescale 1ns/1ps

module exec_cluster_top import gpu_pkg::*; #(
    parameter int NUM_LANES  = 2,
    parameter int ISSUE_CNT  = 4,
    parameter int BLOCK_SIZE = 2,
    parameter int OUT_REG    = 1
) (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      issue_valid,
    input  issue_req_t                issue_data,
    output logic                      issue_ready,

    output logic    [ISSUE_CNT-1:0]   commit_valid,
    output commit_t [ISSUE_CNT-1:0]   commit_data,
    input  logic    [ISSUE_CNT-1:0]   commit_ready
);
    logic      [BLOCK_SIZE-1:0] pkt_valid;
    lane_pkt_t                  pkt_data;
    logic      [BLOCK_SIZE-1:0] pkt_ready;
    logic      [BLOCK_SIZE-1:0] res_valid;
    lane_res_t [BLOCK_SIZE-1:0] res_data;
    logic      [BLOCK_SIZE-1:0] res_ready;

    lane_dispatch #(
        .NUM_LANES  (NUM_LANES),
        .ISSUE_CNT  (ISSUE_CNT),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) dispatch0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .issue_ready (issue_ready),
        .pkt_valid   (pkt_valid),
        .pkt_data    (pkt_data),
        .pkt_ready   (pkt_ready)
    );

    // Every block sees the same packet bus, only its own valid is raised
    for (genvar b = 0; b < BLOCK_SIZE; b++) begin : g_alu
        alu_lanes #(
            .NUM_LANES (NUM_LANES)
        ) alu (
            .clk       (clk),
            .rst_n     (rst_n),
            .pkt_valid (pkt_valid[b]),
            .pkt_data  (pkt_data),
            .pkt_ready (pkt_ready[b]),
            .res_valid (res_valid[b]),
            .res_data  (res_data[b]),
            .res_ready (res_ready[b])
        );
    end

    gather_unit #(
        .NUM_LANES  (NUM_LANES),
        .ISSUE_CNT  (ISSUE_CNT),
        .BLOCK_SIZE (BLOCK_SIZE),
        .OUT_REG    (OUT_REG)
    ) gather0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .res_valid    (res_valid),
        .res_data     (res_data),
        .res_ready    (res_ready),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

endmodule

//--- test/tb_exec_cluster.sv
/*
 * Random self-checking testbench for exec_cluster_top at default parameters.
 * Issues warp instructions, models the expected packets per commit port and
 * checks every commit transfer under random commit back-pressure.
 */
`timescale 1ns/1ps

module tb_exec_cluster import gpu_pkg::*; ;
    localparam int          NUM_LANES  = 2;
    localparam int          ISSUE_CNT  = 4;
    localparam int          NUM_PKTS   = NUM_THREADS / NUM_LANES;
    localparam int          NUM_TESTS  = 300;
    localparam int          CLK_PERIOD = 4;
    localparam logic [31:0] SEED       = 32'h38ad_121a;
    localparam longint      TIMEOUT_NS = (longint'(NUM_TESTS) * 8 * 20 + 8) * CLK_PERIOD;

    logic                           clk;
    logic                           rst_n;
    logic                           issue_valid;
    issue_req_t                     issue_data;
    logic                           issue_ready;
    logic    [ISSUE_CNT-1:0]        commit_valid;
    commit_t [ISSUE_CNT-1:0]        commit_data;
    logic    [ISSUE_CNT-1:0]        commit_ready;

    logic [31:0]            issue_state;
    logic [31:0]            ready_state;
    commit_t                exp_q[ISSUE_CNT][$];
    logic [NUM_THREADS-1:0] mask_q[ISSUE_CNT][$];
    logic [NUM_THREADS-1:0] acc_mask[ISSUE_CNT];
    int                     stall_left[ISSUE_CNT];

    exec_cluster_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_data   (issue_data),
        .issue_ready  (issue_ready),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] issue_rand();
        issue_state = lcg_step(issue_state);
        return issue_state;
    endfunction

    function automatic logic [31:0] ready_rand();
        ready_state = lcg_step(ready_state);
        return ready_state;
    endfunction

    // Reference ALU that decides SLT by the sign bits first and the magnitude second
    function automatic logic [XLEN-1:0] ref_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (op)
            ADD: return a + b;
            SUB: return a + ~b + 1;
            AND: return a & b;
            OR:  return a | b;
            XOR: return a ^ b;
            SLT: begin
                if (a[XLEN-1] != b[XLEN-1]) return XLEN'(a[XLEN-1]);
                return XLEN'(a < b);
            end
            default: return '0;
        endcase
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int p = 0; p < ISSUE_CNT; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        abort_run($sformatf("mismatch %s %s: expected %0h actual %0h", name, field, exp, act));
    endtask

    task automatic compare_ctrl(input string name, input logic [ISSUE_CNT:0] exp,
                                input logic [ISSUE_CNT:0] act);
        if (act !== exp) report_mismatch(name, "issue_ready/commit_valid", exp, act);
    endtask

    task automatic compare_tmask(input string name, input logic [NUM_THREADS-1:0] exp,
                                 input logic [NUM_THREADS-1:0] act);
        if (act !== exp) report_mismatch(name, "accumulated tmask", exp, act);
    endtask

    task automatic compare_commit(input string name, input commit_t exp, input commit_t act);
        if (act.uuid !== exp.uuid) report_mismatch(name, "uuid", exp.uuid, act.uuid);
        if (act.wid !== exp.wid) report_mismatch(name, "wid", exp.wid, act.wid);
        if (act.pc !== exp.pc) report_mismatch(name, "pc", exp.pc, act.pc);
        if (act.rd !== exp.rd) report_mismatch(name, "rd", exp.rd, act.rd);
        if (act.wb !== exp.wb) report_mismatch(name, "wb", exp.wb, act.wb);
        if (act.sop !== exp.sop) report_mismatch(name, "sop", exp.sop, act.sop);
        if (act.eop !== exp.eop) report_mismatch(name, "eop", exp.eop, act.eop);
        if (act.tmask !== exp.tmask) report_mismatch(name, "tmask", exp.tmask, act.tmask);
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (exp.tmask[t] && act.data[t] !== exp.data[t]) begin
                report_mismatch(name, $sformatf("data[%0d]", t), exp.data[t], act.data[t]);
            end
        end
    endtask

    // Builds one expected packet per non-empty slice, widened back to its thread position
    task automatic model_push(input issue_req_t req);
        commit_t pkt;
        int      slot;
        int      last;
        bit      first;
        slot  = int'(req.wid) % ISSUE_CNT;
        last  = -1;
        first = 1'b1;
        for (int p = 0; p < NUM_PKTS; p++) begin
            if (|req.tmask[p*NUM_LANES +: NUM_LANES]) last = p;
        end
        for (int p = 0; p < NUM_PKTS; p++) begin
            if (|req.tmask[p*NUM_LANES +: NUM_LANES]) begin
                pkt      = '0;
                pkt.uuid = req.uuid;
                pkt.wid  = req.wid;
                pkt.pc   = req.pc;
                pkt.rd   = req.rd;
                pkt.wb   = req.wb;
                pkt.sop  = first;
                pkt.eop  = (p == last);
                for (int t = p * NUM_LANES; t < (p + 1) * NUM_LANES; t++) begin
                    pkt.tmask[t] = req.tmask[t];
                    if (req.tmask[t]) pkt.data[t] = ref_alu(req.op, req.rs1[t], req.rs2[t]);
                end
                first = 1'b0;
                exp_q[slot].push_back(pkt);
            end
        end
        mask_q[slot].push_back(req.tmask);
    endtask

    task automatic issue_one(input int idx);
        issue_req_t  req;
        logic [31:0] r;
        r        = issue_rand();
        req      = '0;
        req.uuid = UUID_BITS'(idx);
        req.wid  = r[31:29];
        req.rd   = r[28:24];
        req.wb   = r[23];
        req.op   = alu_op_e'(r[15:8] % 6);
        req.pc   = issue_rand();
        // Full and single-thread masks show up often next to plain random ones
        r = issue_rand();
        case (r[31:30])
            2'd0:    req.tmask = '1;
            2'd1:    req.tmask = NUM_THREADS'(1) << r[2:0];
            default: req.tmask = (r[15:8] != 0) ? r[15:8] : 8'h80;
        endcase
        for (int t = 0; t < NUM_THREADS; t++) begin
            req.rs1[t] = issue_rand();
            req.rs2[t] = r[20] ? req.rs1[t] - 1 : issue_rand();
        end
        @(negedge clk);
        issue_valid = 1'b1;
        issue_data  = req;
        #1;
        while (!issue_ready) begin
            @(negedge clk);
            #1;
        end
        model_push(req);
        @(negedge clk);
        issue_valid = 1'b0;
        issue_data  = '0;
    endtask

    task automatic take_commit(input int p);
        commit_t exp;
        commit_t act;
        string   name;
        act = commit_data[p];
        if (exp_q[p].size() == 0) begin
            abort_run($sformatf("unexpected commit on port %0d with no instruction pending", p));
        end else begin
            exp  = exp_q[p].pop_front();
            name = $sformatf("port %0d uuid %0d", p, exp.uuid);
            compare_commit(name, exp, act);
            acc_mask[p] = acc_mask[p] | act.tmask;
            if (act.eop) begin
                compare_tmask(name, mask_q[p].pop_front(), acc_mask[p]);
                acc_mask[p] = '0;
            end
        end
    endtask

    // Random stall periods per commit port
    always @(negedge clk) begin : ready_drive
        logic [31:0] r;
        for (int p = 0; p < ISSUE_CNT; p++) begin
            r = ready_rand();
            if (stall_left[p] != 0) begin
                stall_left[p]   = stall_left[p] - 1;
                commit_ready[p] = 1'b0;
            end else if (r[31:29] == 3'd0) begin
                stall_left[p]   = int'(r[18:16]);
                commit_ready[p] = 1'b0;
            end else begin
                commit_ready[p] = 1'b1;
            end
        end
    end

    // Sampled mid-cycle, these are the values that transfer on the next rising edge
    always @(negedge clk) begin : commit_monitor
        #1;
        if (rst_n) begin
            for (int p = 0; p < ISSUE_CNT; p++) begin
                if (commit_valid[p] && commit_ready[p]) take_commit(p);
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        abort_run("timeout: commits did not drain within the allowed time");
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue_data   = '0;
        commit_ready = '1;
        issue_state  = SEED;
        ready_state  = lcg_step(SEED);
        for (int p = 0; p < ISSUE_CNT; p++) begin
            acc_mask[p]   = '0;
            stall_left[p] = 0;
        end
        repeat (8) begin
            @(negedge clk);
            compare_ctrl("reset", {1'b1, {ISSUE_CNT{1'b0}}}, {issue_ready, commit_valid});
        end
        rst_n = 1'b1;
        @(negedge clk);
        compare_ctrl("after reset", {1'b1, {ISSUE_CNT{1'b0}}}, {issue_ready, commit_valid});
        for (int n = 0; n < NUM_TESTS; n++) begin
            issue_one(n);
            repeat (int'(issue_rand() >> 30)) @(negedge clk);
        end
        while (pending_count() != 0) @(negedge clk);
        repeat (20) @(negedge clk);
        // Once drained the dispatcher is idle and no port still holds a commit
        if ({issue_ready, commit_valid} === {1'b1, {ISSUE_CNT{1'b0}}}) begin
            $display("Testbench passed");
            $finish;
        end else begin
            report_mismatch("drained", "issue_ready/commit_valid",
                            {1'b1, {ISSUE_CNT{1'b0}}}, {issue_ready, commit_valid});
        end
    end

endmodule

//--- src.f
+incdir+include
source/gpu_pkg.sv
source/lane_dispatch.sv
source/alu_lanes.sv
source/elastic_buffer.sv
source/gather_unit.sv
source/exec_cluster_top.sv
test/tb_exec_cluster.sv

//--- Makefile
# Verilator build for the execution cluster testbench
VERILATOR ?= verilator
TOP       ?= tb_exec_cluster
BUILD_DIR ?= build
SEED_ARGS ?= +verilator+seed+1
FILELIST  ?= src.f
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard source/*.sv) $(wildcard test/*.sv) \
                      $(wildcard include/*.svh)
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The simulator exits non-zero on $fatal, so make reports the failure
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)
